/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= tb_graph_kernel_top
RTL_TOP   ?= graph_kernel_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test OK" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flist.f */
source/graph_kernel_pkg.sv
source/control_chain_if.sv
source/axi_lite_control_regs.sv
source/kernel_control.sv
source/vertex_range_engine.sv
source/graph_kernel_top.sv
testbench/tb_graph_kernel_top.sv

/* source/axi_lite_control_regs.sv */
// AXI4-Lite slave for the kernel: control register, ten descriptor words, result
// Write and read responses are always OKAY, one cycle after the accept

`timescale 1ns/10ps
`default_nettype none

module axi_lite_control_regs (
    input  logic                                       ap_clk,
    input  logic                                       areset_control,
    input  logic [graph_kernel_pkg::addr_w-1:0]        awaddr,
    input  logic                                       awvalid,
    output logic                                       awready,
    input  logic [graph_kernel_pkg::data_w-1:0]        wdata,
    input  logic [graph_kernel_pkg::data_w/8-1:0]      wstrb,
    input  logic                                       wvalid,
    output logic                                       wready,
    output logic [1:0]                                 bresp,
    output logic                                       bvalid,
    input  logic                                       bready,
    input  logic [graph_kernel_pkg::addr_w-1:0]        araddr,
    input  logic                                       arvalid,
    output logic                                       arready,
    output logic [graph_kernel_pkg::data_w-1:0]        rdata,
    output logic [1:0]                                 rresp,
    output logic                                       rvalid,
    input  logic                                       rready,
    control_chain_if.regs                              chain,
    output graph_kernel_pkg::kernel_descriptor_payload_t descriptor,
    input  logic [graph_kernel_pkg::data_w-1:0]        result
);

    // Descriptor storage, word 9 in the top slot
    logic [graph_kernel_pkg::num_buffers-1:0][graph_kernel_pkg::data_w-1:0] buffer_words;

    logic                                  wr_accept;
    logic                                  rd_accept;
    logic [graph_kernel_pkg::addr_w-1:0]   wr_offset;
    logic [graph_kernel_pkg::addr_w-1:0]   rd_offset;
    logic                                  wr_hit_buffer;
    logic                                  rd_hit_buffer;
    logic [graph_kernel_pkg::data_w-1:0]   rd_value;
    logic                                  ap_done_sticky;
    logic                                  ap_done_prev;

    // --------------------
    // Write channel
    // --------------------
    // aw and w taken together, one-cycle ready pulse
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            wr_accept <= 1'b0;
            bvalid    <= 1'b0;
        end else begin
            wr_accept <= awvalid && wvalid && !wr_accept && !bvalid;
            if (wr_accept) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    assign awready = wr_accept;
    assign wready  = wr_accept;
    assign bresp   = 2'b00;

    assign wr_offset     = awaddr - graph_kernel_pkg::buffer_offset;
    assign wr_hit_buffer = (awaddr >= graph_kernel_pkg::buffer_offset)
                           && (wr_offset < graph_kernel_pkg::num_buffers * 4);

    // Byte lanes per strobe
    always_ff @(posedge ap_clk) begin
        if (wr_accept && wr_hit_buffer) begin
            for (int b = 0; b < graph_kernel_pkg::data_w / 8; b++) begin
                if (wstrb[b]) begin
                    buffer_words[wr_offset[graph_kernel_pkg::addr_w-1:2]][b*8 +: 8] <=
                        wdata[b*8 +: 8];
                end
            end
        end
    end

    assign descriptor = graph_kernel_pkg::kernel_descriptor_payload_t'(buffer_words);

    // --------------------
    // Control bits
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            chain.ap_start <= 1'b0;
            ap_done_sticky <= 1'b0;
            ap_done_prev   <= 1'b0;
        end else begin
            ap_done_prev <= chain.ap_done;
            // Host sets start, FSM ready clears it
            if (wr_accept && awaddr == graph_kernel_pkg::ctrl_offset && wstrb[0] && wdata[0]) begin
                chain.ap_start <= 1'b1;
            end else if (chain.ap_ready) begin
                chain.ap_start <= 1'b0;
            end
            // Done level from the FSM stays up in DONE, so latch its edge
            if (chain.ap_done && !ap_done_prev) begin
                ap_done_sticky <= 1'b1;
            end else if (rd_accept && araddr == graph_kernel_pkg::ctrl_offset) begin
                ap_done_sticky <= 1'b0;
            end
        end
    end

    // --------------------
    // Read channel
    // --------------------
    assign arready   = !rvalid;
    assign rd_accept = arvalid && arready;
    assign rresp     = 2'b00;

    assign rd_offset     = araddr - graph_kernel_pkg::buffer_offset;
    assign rd_hit_buffer = (araddr >= graph_kernel_pkg::buffer_offset)
                           && (rd_offset < graph_kernel_pkg::num_buffers * 4);

    always_comb begin
        rd_value = '0;
        if (araddr == graph_kernel_pkg::ctrl_offset) begin
            rd_value[3:0] = {chain.ap_ready, chain.ap_idle, ap_done_sticky, chain.ap_start};
        end else if (araddr == graph_kernel_pkg::result_offset) begin
            rd_value = result;
        end else if (rd_hit_buffer) begin
            rd_value = buffer_words[rd_offset[graph_kernel_pkg::addr_w-1:2]];
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            rvalid <= 1'b0;
        end else if (rd_accept) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (rd_accept) begin
            rdata <= rd_value;
        end
    end

    // Every write response traces back to an accepted aw/w pair
    assert property (@(posedge ap_clk) disable iff (areset_control)
        $rose(bvalid) |-> $past(wr_accept));

endmodule

`default_nettype wire

/* source/control_chain_if.sv */
// ap_ctrl_chain handshake between the AXI4-Lite register block and the control FSM
// Register block holds ap_start and the FSM drives the status and CU control lines

`timescale 1ns/10ps
`default_nettype none

interface control_chain_if (
    input logic ap_clk
);
    logic ap_start;
    logic ap_ready;
    logic ap_done;
    logic ap_idle;
    logic start;
    logic endian_read;
    logic endian_write;

    modport regs (output ap_start, input ap_ready, ap_done, ap_idle);

    modport ctrl (
        input  ap_start,
        output ap_ready, ap_done, ap_idle, start, endian_read, endian_write
    );

endinterface

`default_nettype wire

/* source/graph_kernel_pkg.sv */
// Shared widths, register map, FSM states and descriptor types for the graph kernel shell
// Every design file refers to these by scoped name

`default_nettype none

package graph_kernel_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int data_w      = 32;
    localparam int addr_w      = 8;
    localparam int num_buffers = 10;

    // --------------------
    // AXI4-Lite register map
    // --------------------
    localparam logic [addr_w-1:0] ctrl_offset   = 8'h00;
    // Descriptor word i at buffer_offset + 4*i
    localparam logic [addr_w-1:0] buffer_offset = 8'h10;
    localparam logic [addr_w-1:0] result_offset = 8'h40;

    // Word 0 base vertex, word 1 vertex count, word 9 endian flags
    typedef struct packed {
        logic [data_w-1:0] buffer_9;
        logic [data_w-1:0] buffer_8;
        logic [data_w-1:0] buffer_7;
        logic [data_w-1:0] buffer_6;
        logic [data_w-1:0] buffer_5;
        logic [data_w-1:0] buffer_4;
        logic [data_w-1:0] buffer_3;
        logic [data_w-1:0] buffer_2;
        logic [data_w-1:0] buffer_1;
        logic [data_w-1:0] buffer_0;
    } kernel_descriptor_payload_t;

    typedef struct packed {
        logic                       valid;
        kernel_descriptor_payload_t payload;
    } kernel_descriptor_t;

    // ap_ctrl_chain states
    typedef enum logic [2:0] {
        ctrl_sync_reset,
        ctrl_sync_idle,
        ctrl_sync_setup,
        ctrl_sync_ready,
        ctrl_sync_start,
        ctrl_sync_busy,
        ctrl_sync_done
    } control_sync_state_t;

endpackage

`default_nettype wire

/* source/graph_kernel_top.sv */
// Kernel shell top level with plain AXI4-Lite slave ports
// Joins the register block, control FSM and vertex range engine

`timescale 1ns/10ps
`default_nettype none

module graph_kernel_top (
    input  logic                                  ap_clk,
    input  logic                                  areset_control,
    input  logic [graph_kernel_pkg::addr_w-1:0]   awaddr,
    input  logic                                  awvalid,
    output logic                                  awready,
    input  logic [graph_kernel_pkg::data_w-1:0]   wdata,
    input  logic [graph_kernel_pkg::data_w/8-1:0] wstrb,
    input  logic                                  wvalid,
    output logic                                  wready,
    output logic [1:0]                            bresp,
    output logic                                  bvalid,
    input  logic                                  bready,
    input  logic [graph_kernel_pkg::addr_w-1:0]   araddr,
    input  logic                                  arvalid,
    output logic                                  arready,
    output logic [graph_kernel_pkg::data_w-1:0]   rdata,
    output logic [1:0]                            rresp,
    output logic                                  rvalid,
    input  logic                                  rready
);

    graph_kernel_pkg::kernel_descriptor_payload_t descriptor_payload;
    graph_kernel_pkg::kernel_descriptor_t         cu_descriptor;
    logic                                         cu_setup;
    logic                                         cu_done;
    logic [graph_kernel_pkg::data_w-1:0]          cu_result;

    control_chain_if chain (.ap_clk(ap_clk));

    axi_lite_control_regs i_regs (
        .ap_clk         (ap_clk),
        .areset_control (areset_control),
        .awaddr         (awaddr),
        .awvalid        (awvalid),
        .awready        (awready),
        .wdata          (wdata),
        .wstrb          (wstrb),
        .wvalid         (wvalid),
        .wready         (wready),
        .bresp          (bresp),
        .bvalid         (bvalid),
        .bready         (bready),
        .araddr         (araddr),
        .arvalid        (arvalid),
        .arready        (arready),
        .rdata          (rdata),
        .rresp          (rresp),
        .rvalid         (rvalid),
        .rready         (rready),
        .chain          (chain.regs),
        .descriptor     (descriptor_payload),
        .result         (cu_result)
    );

    kernel_control i_control (
        .ap_clk         (ap_clk),
        .areset_control (areset_control),
        .chain          (chain.ctrl),
        .descriptor_in  (descriptor_payload),
        .descriptor_out (cu_descriptor),
        .cu_setup       (cu_setup),
        .cu_done        (cu_done)
    );

    // CU control lines tapped straight off the chain bundle
    vertex_range_engine i_engine (
        .ap_clk         (ap_clk),
        .areset_control (areset_control),
        .descriptor     (cu_descriptor),
        .start          (chain.start),
        .endian_read    (chain.endian_read),
        .endian_write   (chain.endian_write),
        .setup          (cu_setup),
        .done           (cu_done),
        .result         (cu_result)
    );

endmodule

`default_nettype wire

/* source/kernel_control.sv */
// Block-level ap_ctrl_chain FSM that registers the descriptor and sequences the CU
// Status and CU controls leave through two register stages behind the state

`timescale 1ns/10ps
`default_nettype none

module kernel_control (
    input  logic                                         ap_clk,
    input  logic                                         areset_control,
    control_chain_if.ctrl                                chain,
    input  graph_kernel_pkg::kernel_descriptor_payload_t descriptor_in,
    output graph_kernel_pkg::kernel_descriptor_t         descriptor_out,
    input  logic                                         cu_setup,
    input  logic                                         cu_done
);

    // One bit per state-driven output
    typedef struct packed {
        logic ap_ready;
        logic ap_done;
        logic ap_idle;
        logic start;
        logic valid;
        logic endian_read;
        logic endian_write;
    } ctrl_outputs_t;

    graph_kernel_pkg::control_sync_state_t        state;
    graph_kernel_pkg::control_sync_state_t        next_state;
    graph_kernel_pkg::kernel_descriptor_payload_t descriptor_in_q;
    graph_kernel_pkg::kernel_descriptor_payload_t payload_q;

    logic          ap_start_q;
    logic          cu_setup_q;
    logic          cu_done_q;
    ctrl_outputs_t decode;
    ctrl_outputs_t stage_1;
    ctrl_outputs_t stage_2;

    // --------------------
    // Input registers
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            ap_start_q <= 1'b0;
            // CU assumed free out of reset
            cu_setup_q <= 1'b1;
            cu_done_q  <= 1'b0;
        end else begin
            ap_start_q <= chain.ap_start;
            cu_setup_q <= cu_setup;
            cu_done_q  <= cu_done;
        end
    end

    // Descriptor path, two stages to the CU
    always_ff @(posedge ap_clk) begin
        descriptor_in_q <= descriptor_in;
        payload_q       <= descriptor_in_q;
    end

    // --------------------
    // State machine
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            state <= graph_kernel_pkg::ctrl_sync_reset;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            graph_kernel_pkg::ctrl_sync_reset: next_state = graph_kernel_pkg::ctrl_sync_idle;
            graph_kernel_pkg::ctrl_sync_idle:  next_state = graph_kernel_pkg::ctrl_sync_setup;
            graph_kernel_pkg::ctrl_sync_setup: begin
                if (ap_start_q) begin
                    next_state = graph_kernel_pkg::ctrl_sync_ready;
                end
            end
            // Hold until the CU can take work
            graph_kernel_pkg::ctrl_sync_ready: begin
                if (cu_setup_q) begin
                    next_state = graph_kernel_pkg::ctrl_sync_start;
                end
            end
            graph_kernel_pkg::ctrl_sync_start: next_state = graph_kernel_pkg::ctrl_sync_busy;
            graph_kernel_pkg::ctrl_sync_busy: begin
                if (cu_done_q) begin
                    next_state = graph_kernel_pkg::ctrl_sync_done;
                end
            end
            // Done doubles as idle, next start goes straight to ready
            graph_kernel_pkg::ctrl_sync_done: begin
                if (ap_start_q) begin
                    next_state = graph_kernel_pkg::ctrl_sync_ready;
                end
            end
            default: next_state = graph_kernel_pkg::ctrl_sync_reset;
        endcase
    end

    // --------------------
    // Output decode
    // --------------------
    always_comb begin
        decode = '{ap_idle: 1'b1, default: 1'b0};
        case (state)
            graph_kernel_pkg::ctrl_sync_setup: decode.start = 1'b1;
            graph_kernel_pkg::ctrl_sync_ready: begin
                decode.ap_ready = 1'b1;
                decode.ap_idle  = 1'b0;
                decode.start    = 1'b1;
            end
            graph_kernel_pkg::ctrl_sync_start, graph_kernel_pkg::ctrl_sync_busy: begin
                decode.ap_idle      = 1'b0;
                decode.start        = 1'b1;
                decode.valid        = 1'b1;
                decode.endian_read  = descriptor_in_q.buffer_9[0];
                decode.endian_write = descriptor_in_q.buffer_9[1];
            end
            graph_kernel_pkg::ctrl_sync_done: decode.ap_done = 1'b1;
            default: ;
        endcase
    end

    // Two stages, outputs trail the state by two cycles
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            stage_1 <= '{ap_idle: 1'b1, default: 1'b0};
            stage_2 <= '{ap_idle: 1'b1, default: 1'b0};
        end else begin
            stage_1 <= decode;
            stage_2 <= stage_1;
        end
    end

    assign chain.ap_ready     = stage_2.ap_ready;
    assign chain.ap_done      = stage_2.ap_done;
    assign chain.ap_idle      = stage_2.ap_idle;
    assign chain.start        = stage_2.start;
    assign chain.endian_read  = stage_2.endian_read;
    assign chain.endian_write = stage_2.endian_write;
    assign descriptor_out     = '{valid: stage_2.valid, payload: payload_q};

    assert property (@(posedge ap_clk) disable iff (areset_control)
        !(chain.ap_ready && chain.ap_done));

endmodule

`default_nettype wire

/* source/vertex_range_engine.sv */
// Compute unit that sums base + k for k over the vertex count, one term per cycle
// Result is held until the next run

`timescale 1ns/10ps
`default_nettype none

module vertex_range_engine (
    input  logic                                 ap_clk,
    input  logic                                 areset_control,
    input  graph_kernel_pkg::kernel_descriptor_t descriptor,
    input  logic                                 start,
    input  logic                                 endian_read,
    input  logic                                 endian_write,
    output logic                                 setup,
    output logic                                 done,
    output logic [graph_kernel_pkg::data_w-1:0]  result
);

    typedef enum logic [1:0] {
        engine_idle,
        engine_run,
        // Wait for the FSM to drop valid before rearming
        engine_drain
    } engine_state_t;

    engine_state_t                       state;
    logic [graph_kernel_pkg::data_w-1:0] term_q;
    logic [graph_kernel_pkg::data_w-1:0] remaining_q;
    logic [graph_kernel_pkg::data_w-1:0] acc_q;
    logic                                swap_result_q;

    function automatic logic [graph_kernel_pkg::data_w-1:0] byte_swap(
        input logic [graph_kernel_pkg::data_w-1:0] word
    );
        return {word[7:0], word[15:8], word[23:16], word[31:24]};
    endfunction

    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            state <= engine_idle;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                engine_idle: begin
                    if (descriptor.valid && start) begin
                        state <= engine_run;
                    end
                end
                engine_run: begin
                    if (remaining_q == '0) begin
                        state <= engine_drain;
                        done  <= 1'b1;
                    end
                end
                engine_drain: begin
                    if (!descriptor.valid) begin
                        state <= engine_idle;
                    end
                end
                default: state <= engine_idle;
            endcase
        end
    end

    assign setup = (state == engine_idle);

    // Datapath, reloaded every idle cycle so the capture cycle wins
    always_ff @(posedge ap_clk) begin
        case (state)
            engine_idle: begin
                term_q        <= endian_read ? byte_swap(descriptor.payload.buffer_0)
                                             : descriptor.payload.buffer_0;
                remaining_q   <= endian_read ? byte_swap(descriptor.payload.buffer_1)
                                             : descriptor.payload.buffer_1;
                acc_q         <= '0;
                swap_result_q <= endian_write;
            end
            engine_run: begin
                if (remaining_q != '0) begin
                    // Wraps at 32 bits
                    acc_q       <= acc_q + term_q;
                    term_q      <= term_q + 1'b1;
                    remaining_q <= remaining_q - 1'b1;
                end else begin
                    result <= swap_result_q ? byte_swap(acc_q) : acc_q;
                end
            end
            default: ;
        endcase
    end

    assert property (@(posedge ap_clk) disable iff (areset_control) done |-> !setup);

endmodule

`default_nettype wire

/* testbench/kernel_vectors.txt */
# name base count aux flags expected
# Hex columns; flag bit 0 swaps base and count on the way in, bit 1 swaps the result
plain_small 00000005 00000004 c0de0000 00000000 0000001a
zero_count 00000100 00000000 c0de0100 00000000 00000000
swap_in 10000000 08000000 c0de0200 00000001 0000009c
swap_out 00000020 0000000a c0de0300 00000002 6d010000
swap_both 00010000 0c000000 c0de0400 00000003 420c0000
wrap_around fffffff0 00000020 c0de0500 00000000 fffffff0
large_base 12345678 00000003 c0de0600 00000000 369d036b
one_term a1b2c3d4 00000001 c0de0700 00000002 d4c3b2a1

/* testbench/tb_graph_kernel_top.sv */
// Vector-driven testbench for the graph kernel shell
// Programs descriptors over AXI4-Lite, starts the kernel, polls ap_done and checks the result
// Vectors come from testbench/kernel_vectors.txt, opened relative to the project root

`timescale 1ns/10ps
`default_nettype none

module tb_graph_kernel_top;

    logic                                  ap_clk;
    logic                                  areset_control;
    logic [graph_kernel_pkg::addr_w-1:0]   awaddr;
    logic                                  awvalid;
    logic                                  awready;
    logic [graph_kernel_pkg::data_w-1:0]   wdata;
    logic [graph_kernel_pkg::data_w/8-1:0] wstrb;
    logic                                  wvalid;
    logic                                  wready;
    logic [1:0]                            bresp;
    logic                                  bvalid;
    logic                                  bready;
    logic [graph_kernel_pkg::addr_w-1:0]   araddr;
    logic                                  arvalid;
    logic                                  arready;
    logic [graph_kernel_pkg::data_w-1:0]   rdata;
    logic [1:0]                            rresp;
    logic                                  rvalid;
    logic                                  rready;

    // Cycle limits for bus handshakes and ap_done polling
    int handshake_limit = 50;
    int poll_limit      = 200;

    // Stall generator state
    logic [15:0] lfsr_state;

    // One entry per vector line
    string       names[$];
    logic [31:0] vec_base[$];
    logic [31:0] vec_count[$];
    logic [31:0] vec_aux[$];
    logic [31:0] vec_flags[$];

    graph_kernel_top i_dut (.*);

    initial ap_clk = 1'b0;
    always #4 ap_clk = ~ap_clk;

    // --------------------
    // Reporting
    // --------------------
    task automatic fail_and_stop();
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        fail_and_stop();
    endtask

    task automatic check_equal(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Fail %s: expected %08h, actual %08h", test_name, expected, actual);
            fail_and_stop();
        end
    endtask

    // --------------------
    // Reference model
    // --------------------
    function automatic logic [31:0] reverse_bytes(input logic [31:0] word);
        logic [31:0] swapped;
        for (int b = 0; b < 4; b++) begin
            swapped[8*b +: 8] = word[8*(3-b) +: 8];
        end
        return swapped;
    endfunction

    // AXI write strobes pick the new byte lanes
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] strb);
        logic [31:0] merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    // Sum of base + k over the count, 32-bit wrap, swaps per flag bits
    function automatic logic [31:0] expected_checksum(input logic [31:0] base_word,
                                                      input logic [31:0] count_word,
                                                      input logic [31:0] flags);
        logic [31:0] base;
        logic [31:0] count;
        logic [31:0] sum;
        base  = flags[0] ? reverse_bytes(base_word) : base_word;
        count = flags[0] ? reverse_bytes(count_word) : count_word;
        sum   = '0;
        for (int unsigned k = 0; k < count; k++) begin
            sum = sum + base + k;
        end
        return flags[1] ? reverse_bytes(sum) : sum;
    endfunction

    function automatic logic [graph_kernel_pkg::addr_w-1:0] word_addr(input int i);
        return graph_kernel_pkg::buffer_offset + 8'(4 * i);
    endfunction

    // Words 2 to 8 carry filler derived from the aux column
    function automatic logic [31:0] descriptor_word(input int v, input int i);
        case (i)
            0: return vec_base[v];
            1: return vec_count[v];
            9: return vec_flags[v];
            default: return vec_aux[v] + 32'(i);
        endcase
    endfunction

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // Two fresh bits per stall, 0 to 3 cycles
    task automatic draw_stall(output int stall);
        stall = 0;
        for (int b = 0; b < 2; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            stall      = (stall << 1) | int'(lfsr_state[0]);
        end
    endtask

    // --------------------
    // AXI4-Lite bus tasks
    // --------------------
    task automatic axi_write(input logic [graph_kernel_pkg::addr_w-1:0] addr,
                             input logic [31:0] data, input logic [3:0] strb);
        int cycles;
        int stall;
        @(posedge ap_clk);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= strb;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        cycles = 0;
        @(negedge ap_clk);
        while (!(awready && wready) && cycles < handshake_limit) begin
            @(negedge ap_clk);
            cycles++;
        end
        assert (awready && wready) else report_timeout("awready and wready");
        // aw and w accepted on this edge
        @(posedge ap_clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        draw_stall(stall);
        repeat (stall) @(posedge ap_clk);
        cycles = 0;
        @(negedge ap_clk);
        while (!bvalid && cycles < handshake_limit) begin
            @(negedge ap_clk);
            cycles++;
        end
        assert (bvalid) else report_timeout("bvalid");
        check_equal("write response code", 32'h0, {30'h0, bresp});
        @(posedge ap_clk);
        bready <= 1'b1;
        @(posedge ap_clk);
        bready <= 1'b0;
        @(negedge ap_clk);
        assert (!bvalid) else begin
            $display("Write response still pending after the bready handshake");
            fail_and_stop();
        end
    endtask

    task automatic axi_read(input logic [graph_kernel_pkg::addr_w-1:0] addr,
                            output logic [31:0] data);
        int cycles;
        int stall;
        @(posedge ap_clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        cycles = 0;
        @(negedge ap_clk);
        while (!arready && cycles < handshake_limit) begin
            @(negedge ap_clk);
            cycles++;
        end
        assert (arready) else report_timeout("arready");
        @(posedge ap_clk);
        arvalid <= 1'b0;
        draw_stall(stall);
        repeat (stall) @(posedge ap_clk);
        cycles = 0;
        @(negedge ap_clk);
        while (!rvalid && cycles < handshake_limit) begin
            @(negedge ap_clk);
            cycles++;
        end
        assert (rvalid) else report_timeout("rvalid");
        check_equal("read response code", 32'h0, {30'h0, rresp});
        data = rdata;
        @(posedge ap_clk);
        rready <= 1'b1;
        @(posedge ap_clk);
        rready <= 1'b0;
        @(negedge ap_clk);
        assert (!rvalid) else begin
            $display("Read response still pending after the rready handshake");
            fail_and_stop();
        end
    endtask

    // --------------------
    // Vector file
    // --------------------
    task automatic load_vectors();
        int               fd;
        int               got;
        int               fields;
        logic [8*128-1:0] line_buf;
        logic [8*32-1:0]  name_buf;
        logic [31:0]      base;
        logic [31:0]      count;
        logic [31:0]      aux;
        logic [31:0]      flags;
        logic [31:0]      expected;
        fd = $fopen("testbench/kernel_vectors.txt", "r");
        assert (fd != 0) else begin
            $display("Could not open the vector file testbench/kernel_vectors.txt");
            fail_and_stop();
        end
        while (!$feof(fd)) begin
            got = $fgets(line_buf, fd);
            // Comment and blank lines never yield six fields
            if (got != 0) begin
                fields = $sscanf(line_buf, "%s %h %h %h %h %h",
                                 name_buf, base, count, aux, flags, expected);
                if (fields == 6) begin
                    names.push_back($sformatf("%0s", name_buf));
                    vec_base.push_back(base);
                    vec_count.push_back(count);
                    vec_aux.push_back(aux);
                    vec_flags.push_back(flags);
                    check_equal({names[$], " vector expectation"},
                                expected_checksum(base, count, flags), expected);
                end
            end
        end
        $fclose(fd);
        assert (names.size() > 0) else begin
            $display("The vector file holds no usable lines");
            fail_and_stop();
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        logic [31:0] rd;
        int          polls;
        areset_control = 1'b1;
        awaddr         = '0;
        awvalid        = 1'b0;
        wdata          = '0;
        wstrb          = '0;
        wvalid         = 1'b0;
        bready         = 1'b0;
        araddr         = '0;
        arvalid        = 1'b0;
        rready         = 1'b0;
        lfsr_state     = 16'd70;
        load_vectors();
        repeat (10) @(posedge ap_clk);
        areset_control <= 1'b0;

        // Idle only, no start, done or ready
        axi_read(graph_kernel_pkg::ctrl_offset, rd);
        check_equal("control after reset", 32'h4, rd);

        // Partial strobes merge into the held word
        axi_write(word_addr(3), 32'h11223344, 4'hF);
        axi_write(word_addr(3), 32'hAABBCCDD, 4'b0101);
        axi_read(word_addr(3), rd);
        check_equal("strobe merge", merge_bytes(32'h11223344, 32'hAABBCCDD, 4'b0101), rd);

        // Runs back to back, flags change from vector to vector
        for (int v = 0; v < names.size(); v++) begin
            for (int i = 0; i < graph_kernel_pkg::num_buffers; i++) begin
                axi_write(word_addr(i), descriptor_word(v, i), 4'hF);
            end
            for (int i = 0; i < graph_kernel_pkg::num_buffers; i++) begin
                axi_read(word_addr(i), rd);
                check_equal($sformatf("%s word %0d", names[v], i), descriptor_word(v, i), rd);
            end
            axi_write(graph_kernel_pkg::ctrl_offset, 32'h1, 4'hF);
            polls = 0;
            rd    = '0;
            while (rd[1] == 1'b0 && polls < poll_limit) begin
                axi_read(graph_kernel_pkg::ctrl_offset, rd);
                polls++;
            end
            assert (rd[1]) else report_timeout({names[v], " ap_done"});
            // Sticky done gone after the first read, idle back
            axi_read(graph_kernel_pkg::ctrl_offset, rd);
            check_equal({names[v], " control after done"}, 32'h4, rd);
            axi_read(graph_kernel_pkg::result_offset, rd);
            check_equal({names[v], " result"},
                        expected_checksum(vec_base[v], vec_count[v], vec_flags[v]), rd);
        end

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
